// ==== cpu_cfg.svh ====
/*
 * Build constants for the 16-bit execute stage
 * Word width, register count and register index width
 */

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and instruction word width
`define CPU_WORD_W 16

// Architectural registers, R0 reads as zero
`define CPU_REG_CNT 16

// Bits needed to name one register
`define CPU_REG_IDX_W 4

`endif

// ==== isa_pkg.sv ====
/*
 * Instruction set types
 * Opcode encoding and the two views of a 16-bit instruction word
 */

`include "cpu_cfg.svh"

package isa_pkg;

  localparam int OPC_W = 4;                                  // Opcode field width
  localparam int IMM_W = `CPU_WORD_W - OPC_W - `CPU_REG_IDX_W; // Immediate width

  //////////////////////////////////////////////////////////////////////////
  // Opcodes, C to F are unused and decode as illegal
  //////////////////////////////////////////////////////////////////////////
  typedef enum logic [OPC_W-1:0] {
    OP_ADD    = 4'h0,  // Saturating add
    OP_SUB    = 4'h1,  // Saturating subtract
    OP_XOR    = 4'h2,
    OP_RED    = 4'h3,  // Byte reduction sum
    OP_SLL    = 4'h4,
    OP_SRA    = 4'h5,
    OP_ROR    = 4'h6,
    OP_PADDSB = 4'h7,  // Four saturating nibble lanes
    OP_LW     = 4'h8,
    OP_SW     = 4'h9,
    OP_LLB    = 4'hA,  // Load low byte
    OP_LHB    = 4'hB   // Load high byte
  } opcode_e;

  // Register to register form
  typedef struct packed {
    opcode_e                   opcode;
    logic [`CPU_REG_IDX_W-1:0] rd;  // Destination
    logic [`CPU_REG_IDX_W-1:0] rs;  // First source
    logic [`CPU_REG_IDX_W-1:0] rt;  // Second source
  } instr_r_t;

  // Immediate form, used by LLB and LHB
  typedef struct packed {
    opcode_e                   opcode;
    logic [`CPU_REG_IDX_W-1:0] rd;   // Destination, also read back
    logic [IMM_W-1:0]          imm;  // Byte immediate
  } instr_i_t;

  // Same word, decoded either way
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// ==== alu_pkg.sv ====
/*
 * ALU and write-back types
 * Request and response records, status flags and the register write record
 */

`include "cpu_cfg.svh"

package alu_pkg;

  // Status flags, also used as per-flag enables
  typedef struct packed {
    logic z;  // Zero
    logic v;  // Overflow
    logic n;  // Negative
  } flags_t;

  // Operation sent to the ALU
  typedef struct packed {
    isa_pkg::opcode_e      op;
    logic [`CPU_WORD_W-1:0] a;  // First operand
    logic [`CPU_WORD_W-1:0] b;  // Second operand or immediate
  } alu_req_t;

  // ALU answer, same cycle
  typedef struct packed {
    logic [`CPU_WORD_W-1:0] result;
    flags_t                 set;    // Flag set signals
    logic                   error;  // Unknown opcode
  } alu_rsp_t;

  // Register file write port
  typedef struct packed {
    logic                      we;
    logic [`CPU_REG_IDX_W-1:0] idx;
    logic [`CPU_WORD_W-1:0]    data;
  } wb_t;

endpackage

// ==== alu.sv ====
/*
 * Execute stage ALU
 * Purely combinational, produces result, Z/V/N set signals and an error
 * flag for unknown opcodes
 */

`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu
  import isa_pkg::*;
  import alu_pkg::*;
(
  input  alu_req_t req,  // Opcode and operands
  output alu_rsp_t rsp   // Result, flag set signals, error
);

  localparam int W    = `CPU_WORD_W;
  localparam int B    = W / 2;        // Byte width
  localparam int SH_W = $clog2(W);    // Shift amount bits
  localparam int LN   = W / 4;        // PADDSB lane count

  localparam logic [W-1:0] SAT_POS = {1'b0, {(W-1){1'b1}}};  // 7FFF
  localparam logic [W-1:0] SAT_NEG = {1'b1, {(W-1){1'b0}}};  // 8000

  logic           is_mem;            // LW or SW
  logic [W-1:0]   a_in, b_in;        // Operands after address adjust
  logic [W-1:0]   sum, diff;         // Raw wrapped results
  logic [W-1:0]   red_sum;
  logic [2*W-1:0] ror_pair;          // Doubled word for rotate
  logic [W-1:0]   paddsb;
  logic [3:0]     lane_a, lane_b, lane_s;
  logic           pos_ov, neg_ov;
  logic [W-1:0]   res;
  logic           err;

  // Sign extend one byte to a word
  function automatic logic [W-1:0] sext_b(input logic [B-1:0] x);
    return {{(W-B){x[B-1]}}, x};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////////////////////
  assign is_mem = (req.op == OP_LW) || (req.op == OP_SW);

  // Address is word aligned base plus offset times two
  assign a_in = is_mem ? {req.a[W-1:1], 1'b0} : req.a;
  assign b_in = is_mem ? {req.b[W-2:0], 1'b0} : req.b;

  assign sum      = a_in + b_in;
  assign diff     = a_in - b_in;
  assign red_sum  = sext_b(a_in[W-1:B]) + sext_b(a_in[B-1:0])
                  + sext_b(b_in[W-1:B]) + sext_b(b_in[B-1:0]);
  assign ror_pair = {a_in, a_in} >> b_in[SH_W-1:0];

  // Nibble lanes, each clamps to 7 or 8 on overflow
  always_comb begin
    paddsb = '0;
    lane_a = '0;
    lane_b = '0;
    lane_s = '0;
    for (int l = 0; l < LN; l++) begin
      lane_a = a_in[4*l +: 4];
      lane_b = b_in[4*l +: 4];
      lane_s = lane_a + lane_b;
      if (!lane_a[3] && !lane_b[3] && lane_s[3]) begin
        lane_s = 4'h7;                 // Positive overflow
      end else if (lane_a[3] && lane_b[3] && !lane_s[3]) begin
        lane_s = 4'h8;                 // Negative overflow
      end
      paddsb[4*l +: 4] = lane_s;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    res    = '0;
    err    = 1'b0;
    pos_ov = 1'b0;
    neg_ov = 1'b0;
    case (req.op)
      OP_ADD: begin
        pos_ov = ~a_in[W-1] & ~b_in[W-1] &  sum[W-1];
        neg_ov =  a_in[W-1] &  b_in[W-1] & ~sum[W-1];
        res    = pos_ov ? SAT_POS : (neg_ov ? SAT_NEG : sum);
      end
      OP_SUB: begin
        pos_ov = ~a_in[W-1] &  b_in[W-1] &  diff[W-1];
        neg_ov =  a_in[W-1] & ~b_in[W-1] & ~diff[W-1];
        res    = pos_ov ? SAT_POS : (neg_ov ? SAT_NEG : diff);
      end
      OP_XOR:       res = a_in ^ b_in;
      OP_RED:       res = red_sum;
      OP_SLL:       res = a_in << b_in[SH_W-1:0];
      OP_SRA:       res = $signed(a_in) >>> b_in[SH_W-1:0];  // Keeps sign
      OP_ROR:       res = ror_pair[W-1:0];
      OP_PADDSB:    res = paddsb;
      OP_LW, OP_SW: res = sum;                                // No saturation
      OP_LLB:       res = {a_in[W-1:B], b_in[B-1:0]};
      OP_LHB:       res = {b_in[B-1:0], a_in[B-1:0]};
      default:      err = 1'b1;                               // Codes C to F
    endcase
  end

  // Set signals, flag_reg picks which ones apply
  assign rsp = '{
    result: res,
    set:    '{z: (res == '0), v: (pos_ov | neg_ov), n: res[W-1]},
    error:  err
  };

endmodule

// ==== flag_reg.sv ====
/*
 * Z/V/N status flag register
 * Loads only the flags that the current opcode class is allowed to change
 */

`timescale 1ns/1ps

module flag_reg
  import isa_pkg::*;
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    load,   // Valid and legal instruction
  input  opcode_e op,
  input  flags_t  set,    // Set signals from the ALU
  output flags_t  flags
);

  flags_t upd;  // Per-flag update enable

  // Arithmetic touches all three, logic and shifts only Z
  always_comb begin
    case (op)
      OP_ADD, OP_SUB:                 upd = '{z: 1'b1, v: 1'b1, n: 1'b1};
      OP_XOR, OP_SLL, OP_SRA, OP_ROR: upd = '{z: 1'b1, v: 1'b0, n: 1'b0};
      default:                        upd = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (load) begin
      if (upd.z) flags.z <= set.z;
      if (upd.v) flags.v <= set.v;
      if (upd.n) flags.n <= set.n;
    end
  end

endmodule

// ==== reg_file.sv ====
/*
 * Register file
 * Sixteen words, two combinational read ports, one write port,
 * R0 hardwired to zero, write data bypassed to matching reads
 */

`timescale 1ns/1ps
`include "cpu_cfg.svh"

module reg_file
  import alu_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`CPU_REG_IDX_W-1:0] rd_idx_a,
  input  logic [`CPU_REG_IDX_W-1:0] rd_idx_b,
  output logic [`CPU_WORD_W-1:0]    rd_data_a,
  output logic [`CPU_WORD_W-1:0]    rd_data_b,
  input  wb_t                       wb         // Write port
);

  logic [`CPU_WORD_W-1:0] regs [`CPU_REG_CNT];

  // One read port, R0 first, then bypass, then storage
  function automatic logic [`CPU_WORD_W-1:0] read_port(
    input logic [`CPU_REG_IDX_W-1:0] idx
  );
    if (idx == '0) begin
      return '0;
    end else if (wb.we && (wb.idx == idx)) begin
      return wb.data;            // Same edge write seen now
    end
    return regs[idx];
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_idx_a);
    rd_data_b = read_port(rd_idx_b);
  end

  // Writes to R0 are dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CPU_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && (wb.idx != '0)) begin
      regs[wb.idx] <= wb.data;
    end
  end

endmodule

// ==== exec_unit.sv ====
/*
 * Execute stage top level
 * Decodes one instruction per cycle, reads operands, runs the ALU and
 * registers result, write-back and flags with one cycle latency
 */

`timescale 1ns/1ps
`include "cpu_cfg.svh"

module exec_unit
  import isa_pkg::*;
  import alu_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_valid,   // One instruction per high cycle
  input  instr_u                 instr,
  output logic                   result_valid,  // Pulse, one cycle after issue
  output logic [`CPU_WORD_W-1:0] result,
  output wb_t                    wb,            // Written at the next edge
  output flags_t                 flags,
  output logic                   illegal        // Pulse for codes C to F
);

  localparam int W  = `CPU_WORD_W;
  localparam int IW = `CPU_REG_IDX_W;

  opcode_e  op;
  logic     is_imm, is_mem;
  logic [IW-1:0] idx_a, idx_b;     // Register read indices
  logic [W-1:0]  data_a, data_b;
  alu_req_t alu_req;
  alu_rsp_t alu_rsp;
  logic     flag_load;
  logic     wb_we_d, wb_we_q;
  logic [IW-1:0] wb_idx_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////
  assign op     = instr.r.opcode;
  assign is_imm = (op == OP_LLB) || (op == OP_LHB);
  assign is_mem = (op == OP_LW)  || (op == OP_SW);

  // Byte loads merge into their own destination
  assign idx_a = is_imm ? instr.i.rd : instr.r.rs;
  assign idx_b = is_imm ? '0 : instr.r.rt;   // R0, unused for I-format

  assign alu_req = '{
    op: op,
    a:  data_a,
    b:  is_imm ? W'(instr.i.imm) : data_b    // Zero extended immediate
  };

  assign flag_load = instr_valid & ~alu_rsp.error;
  assign wb_we_d   = flag_load & ~is_mem & (instr.r.rd != '0);

  reg_file u_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_idx_a  (idx_a),
    .rd_idx_b  (idx_b),
    .rd_data_a (data_a),
    .rd_data_b (data_b),
    .wb        (wb)
  );

  alu u_alu (
    .req (alu_req),
    .rsp (alu_rsp)
  );

  flag_reg u_flag_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (flag_load),
    .op     (op),
    .set    (alu_rsp.set),
    .flags  (flags)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result stage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      illegal      <= 1'b0;
      wb_we_q      <= 1'b0;
    end else begin
      result_valid <= instr_valid;
      illegal      <= instr_valid & alu_rsp.error;
      wb_we_q      <= wb_we_d;
    end
  end

  // Payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      result   <= alu_rsp.result;
      wb_idx_q <= instr.r.rd;
    end
  end

  assign wb = '{we: wb_we_q, idx: wb_idx_q, data: result};

endmodule

// ==== exec_unit_checker.sv ====
/*
 * Execute stage protocol checker
 * Bound into exec_unit, watches strobe timing and the write-back record
 */

`timescale 1ns/1ps

module exec_unit_checker
  import alu_pkg::*;
(
  input logic clk,
  input logic arst_n,
  input logic instr_valid,
  input logic result_valid,
  input logic illegal,
  input wb_t  wb
);

  // Result strobe trails the instruction strobe by exactly one edge
  a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid |=> result_valid)
    else $error("result_valid missing one cycle after instr_valid");

  a_valid_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !instr_valid |=> !result_valid)
    else $error("result_valid high without an instruction");

  a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
    wb.we |-> (wb.idx != '0))
    else $error("write-back enabled with destination R0");

  a_illegal_no_wb: assert property (@(posedge clk) disable iff (!arst_n)
    !(illegal && wb.we))
    else $error("illegal instruction enabled a write-back");

  // Quiet outputs while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> (!result_valid && !illegal && !wb.we))
    else $error("outputs active during reset");

endmodule

bind exec_unit exec_unit_checker u_checker (
  .clk          (clk),
  .arst_n       (arst_n),
  .instr_valid  (instr_valid),
  .result_valid (result_valid),
  .illegal      (illegal),
  .wb           (wb)
);

// ==== exec_unit_tb.sv ====
/*
 * Execute stage testbench
 * LLB/LHB preload, directed corners, then random instructions from an LFSR
 * checked one cycle after issue against a register and flag model
 */

`timescale 1ns/1ps
`include "cpu_cfg.svh"

module exec_unit_tb
  import isa_pkg::*;
  import alu_pkg::*;
();

  localparam int CLK_NS      = 4;
  localparam int N_RANDOM    = 2000;                                 // Random instructions
  localparam int N_DIRECT    = 64;                                   // Preload and corners
  localparam int WATCHDOG_NS = (N_RANDOM + N_DIRECT) * 4 * CLK_NS + 400;

  // Expected outputs for one issue slot
  typedef struct packed {
    logic        valid;
    logic        illegal;
    logic [15:0] result;
    logic        we;
    logic [3:0]  idx;
    flags_t      flags;
  } expect_t;

  logic        clk, arst_n, instr_valid;
  logic [15:0] instr;
  logic        result_valid, illegal;
  logic [15:0] result;
  wb_t         wb;
  flags_t      flags;

  logic [31:0] lfsr;                // Random source state
  logic [15:0] m_regs [16];         // Model register file
  flags_t      m_flags;
  expect_t     exp_near, exp_far;   // Issued one and two edges ago
  logic [3:0]  last_rd;
  int          n_checks, n_errors;

  exec_unit u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result),
    .wb           (wb),
    .flags        (flags),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] enc(input logic [3:0] op, rd, rs, rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] rand_instr();
    logic [3:0] op, rd, rs, rt;
    if (take_bits(4) == 0) begin
      op = 4'hC + 4'(take_bits(2));      // About one in sixteen is illegal
    end else begin
      op = 4'(take_bits(4));
      if (op > 4'hB) op = op - 4'h4;     // Fold C..F onto the memory and byte ops
    end
    rd = 4'(take_bits(4));
    rs = 4'(take_bits(4));
    rt = 4'(take_bits(4));
    if (take_bits(2) == 0) rs = last_rd; // Chain on the previous destination
    last_rd = rd;
    return {op, rd, rs, rt};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model applying one instruction in program order
  ////////////////////////////////////////////////////////////////////////////
  task automatic predict(input logic v, input logic [15:0] w, output expect_t e);
    logic [3:0]  op, rd;
    logic [15:0] a, b, res;
    logic        ovf, bad, we;
    int          s;
    e = '0;
    e.flags = m_flags;                   // Idle slot keeps flags
    if (v) begin
      op  = w[15:12];
      rd  = w[11:8];
      a   = m_regs[w[7:4]];
      b   = m_regs[w[3:0]];
      res = '0;
      ovf = 1'b0;
      bad = 1'b0;
      case (op)
        OP_ADD, OP_SUB: begin
          if (op == OP_ADD) s = int'($signed(a)) + int'($signed(b));
          else              s = int'($signed(a)) - int'($signed(b));
          ovf = (s > 32767) || (s < -32768);
          res = (s > 32767) ? 16'h7fff : ((s < -32768) ? 16'h8000 : 16'(s));
        end
        OP_XOR: res = a ^ b;
        OP_RED: begin
          s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
            + int'($signed(b[15:8])) + int'($signed(b[7:0]));
          res = 16'(s);
        end
        OP_SLL: begin
          res = a;
          for (int i = 0; i < int'(b[3:0]); i++) res = {res[14:0], 1'b0};
        end
        OP_SRA: begin
          res = a;
          for (int i = 0; i < int'(b[3:0]); i++) res = {res[15], res[15:1]};
        end
        OP_ROR: begin
          res = a;
          for (int i = 0; i < int'(b[3:0]); i++) res = {res[0], res[15:1]};
        end
        OP_PADDSB: begin
          for (int l = 0; l < 4; l++) begin
            s = int'($signed(a[4*l +: 4])) + int'($signed(b[4*l +: 4]));
            if (s > 7) s = 7;
            else if (s < -8) s = -8;     // Lane clamps to 7 or 8
            res[4*l +: 4] = 4'(s);
          end
        end
        OP_LW, OP_SW: res = (a & 16'hfffe) + (b << 1);
        OP_LLB: res = {m_regs[rd][15:8], w[7:0]};
        OP_LHB: res = {w[7:0], m_regs[rd][7:0]};
        default: bad = 1'b1;             // Codes C to F
      endcase
      case (op)
        OP_ADD, OP_SUB:                 m_flags = '{z: (res == '0), v: ovf, n: res[15]};
        OP_XOR, OP_SLL, OP_SRA, OP_ROR: m_flags.z = (res == '0);
        default: ;
      endcase
      we = !bad && (op != OP_LW) && (op != OP_SW) && (rd != '0);
      if (we) m_regs[rd] = res;
      e = '{valid: 1'b1, illegal: bad, result: res, we: we, idx: rd, flags: m_flags};
    end
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_outputs(input expect_t e);
    check_val("result_valid", 16'(result_valid), 16'(e.valid));
    check_val("illegal", 16'(illegal), 16'(e.illegal));
    check_val("wb.we", 16'(wb.we), 16'(e.we));
    check_val("flags", 16'(flags), 16'(e.flags));
    if (e.valid) begin                   // Payload holds during gaps
      check_val("result", result, e.result);
      check_val("wb.idx", 16'(wb.idx), 16'(e.idx));
      check_val("wb.data", wb.data, e.result);
    end
  endtask

  // Check the slot issued two edges back and drive the next one
  task automatic cycle(input logic v, input logic [15:0] w);
    expect_t e;
    @(posedge clk);
    check_outputs(exp_far);
    instr_valid <= v;
    instr       <= w;
    predict(v, w, e);
    exp_far  = exp_near;
    exp_near = e;
  endtask

  task automatic load_word(input logic [3:0] rd, input logic [15:0] val);
    cycle(1'b1, enc(OP_LLB, rd, val[7:4], val[3:0]));
    cycle(1'b1, enc(OP_LHB, rd, val[15:12], val[11:8]));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] word;
    arst_n      <= 1'b0;
    instr_valid <= 1'b0;
    instr       <= '0;
    lfsr     = 32'h9c39_e05c;
    m_flags  = '0;
    exp_near = '0;
    exp_far  = '0;
    last_rd  = '0;
    n_checks = 0;
    n_errors = 0;
    for (int r = 0; r < 16; r++) m_regs[r] = '0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // Fill every register including R0 so the dropped write shows
    for (int r = 0; r < 16; r++) begin
      word = 16'(take_bits(16));
      load_word(4'(r), word);
    end

    load_word(4'd1, 16'h7fff);
    load_word(4'd2, 16'h0001);
    load_word(4'd3, 16'h8000);
    load_word(4'd8, 16'h000f);                    // Shift amount 15
    cycle(1'b1, enc(OP_ADD, 4'd4, 4'd1, 4'd2));   // Positive saturation
    cycle(1'b1, enc(OP_SUB, 4'd5, 4'd3, 4'd2));   // Negative saturation
    cycle(1'b1, enc(OP_ADD, 4'd6, 4'd1, 4'd0));   // Read back through R0
    cycle(1'b1, enc(OP_ADD, 4'd6, 4'd6, 4'd3));   // Dependent sum FFFF with no overflow
    cycle(1'b1, enc(OP_SRA, 4'd7, 4'd3, 4'd8));
    cycle(1'b1, enc(OP_SLL, 4'd9, 4'd2, 4'd0));   // Shift by zero
    cycle(1'b1, enc(OP_ROR, 4'd10, 4'd1, 4'd8));
    cycle(1'b1, enc(OP_PADDSB, 4'd11, 4'd1, 4'd1));

    for (int k = 0; k < N_RANDOM; k++) begin
      if (take_bits(3) == 0) cycle(1'b0, 16'(take_bits(16)));  // Gap with junk word
      cycle(1'b1, rand_instr());
    end
    cycle(1'b0, '0);                     // Drain the last two slots
    cycle(1'b0, '0);

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the instruction sequence finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
isa_pkg.sv
alu_pkg.sv
alu.sv
flag_reg.sv
reg_file.sv
exec_unit.sv
exec_unit_checker.sv
exec_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
